// File: files.f
+incdir+hw
hw/dcachePkg.sv
hw/dcacheStore.sv
hw/dcacheCtrl.sv
hw/dcacheTop.sv
tests/dcache_assert.sv
tests/dcache_tb.sv

// File: Makefile
# Verilator build and run for the data cache testbench

VERILATOR ?= verilator
TOP       ?= dcacheTb
FILELIST  ?= files.f
OBJDIR    ?= obj_dir
VFLAGS    ?= --binary --assert
PASSTEXT  ?= RESULT: PASS

SIM := $(OBJDIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile: $(SIM)

$(SIM): $(FILELIST) $(wildcard hw/*.sv hw/*.svh tests/*.sv)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJDIR) -f $(FILELIST)

run: $(SIM)
	@out="$$(./$(SIM))"; echo "$$out"; echo "$$out" | grep -q "$(PASSTEXT)"

clean:
	rm -rf $(OBJDIR)

// File: tests/dcache_tb.sv
// data cache testbench with clock, reset, memory and coherence models, stimulus table and checks
`include "dcache_params.svh"

module dcacheTb;
  timeunit 1ns;
  timeprecision 100ps;
  import dcachePkg::*;

  typedef enum logic [2:0] {opLoad, opStore, opSnoopRd, opSnoopInv, opFlush} opKind;
  typedef struct packed {
    opKind  op;
    memWord addr;
    memWord data;
    memWord expData;    // load result only
  } stimRow;

  localparam int waitLimit = 200;   // cycles allowed per wait

  logic     CLK = 1'b0;
  logic     rstN, dmemRen, dmemWen, halt, memWait, ccWait, ccInv;
  memWord   dmemAddr, dmemStore, memLoad, ccSnoopAddr, dmemLoad, memAddr, memStore;
  logic     dHit, memRen, memWen, ccTrans, ccWrite, ccDone, flushed;

  memWord   memArr [256];          // bus memory indexed by addr[9:2]
  memWord   refMem [256];          // expected memory contents
  lineState refSt [`DC_SETS];      // expected MSI state per set
  logic [`DC_TAG_W-1:0] refTag [`DC_SETS];
  memWord   refData [`DC_SETS][2];
  stimRow   rows [$];
  memWord   wbAddrQ [$], wbDataQ [$], expAddrQ [$], expDataQ [$];
  int       rdBeats, rdxBeats, upBeats, expRd, expRdx, expUp, stallLeft;
  int       rowErrs, errCount, badRows, rowsRun;
  logic     hung, nextWait;
  memWord   nextLoad;

  dcacheTop u_dut (.*);

  always #20 CLK = ~CLK;   // 40 ns period

  // memory and arbiter model sampling mid-cycle and driving after the edge
  initial
  begin
    void'($urandom(32'ha71b_8704));   // seed for the stall lengths
    forever
    begin
      @(negedge CLK);
      nextWait = 1'b1;
      if (rstN && !memWait)
      begin
        if (memWen)
        begin
          memArr[memAddr[9:2]] = memStore;
          wbAddrQ.push_back(memAddr);
          wbDataQ.push_back(memStore);
        end
        else if (memRen)
        begin
          if (ccTrans)
            rdBeats++;    // fill inside an own transaction
          if (ccWrite)
            rdxBeats++;   // fill for a store asks for ownership
        end
        else if (ccTrans && ccWrite)
          upBeats++;   // upgrade grant without data
      end
      else if (rstN && (memRen || memWen || ccTrans))
      begin
        if (stallLeft == 0)
        begin
          nextWait  = 1'b0;
          nextLoad  = memArr[memAddr[9:2]];
          stallLeft = int'($urandom_range(3, 0));
        end
        else
          stallLeft--;
      end
      @(posedge CLK);
      #1;
      memWait = nextWait;
      memLoad = nextLoad;
    end
  end

  task automatic checkWord(memWord got, memWord want, string what);
    if (got !== want)
    begin
      $display("Mismatch at %0t ns: %s is %h, expected %h", $time, what, got, want);
      rowErrs++;
    end
  endtask

  task automatic checkCount(int got, int want, string what);
    if (got != want)
    begin
      $display("Mismatch at %0t ns: %s is %0d, expected %0d", $time, what, got, want);
      rowErrs++;
    end
  endtask

  task automatic addRow(opKind op, memWord addr, memWord data, memWord expData);
    rows.push_back(stimRow'{op, addr, data, expData});
  endtask

  // both words of a dirty line go back to memory
  task automatic expectWriteBack(logic [`DC_IDX_W-1:0] set);
    memWord a;
    for (int w = 0; w < 2; w++)
    begin
      a = {refTag[set], set, 1'(w), 2'b00};
      expAddrQ.push_back(a);
      expDataQ.push_back(refData[set][w]);
      refMem[a[9:2]] = refData[set][w];
    end
  endtask

  // reference MSI model giving bus traffic and new line contents
  task automatic predict(stimRow r);
    logic [`DC_IDX_W-1:0] set;
    logic [`DC_TAG_W-1:0] tag;
    logic                 w, present;
    set     = r.addr[5:3];
    tag     = r.addr[31:6];
    w       = r.addr[2];
    present = (refSt[set] != lineInvalid) && (refTag[set] == tag);
    case (r.op)
      opLoad, opStore:
      begin
        if (!present)
        begin
          if (refSt[set] == lineModified)
            expectWriteBack(set);   // dirty victim first
          refData[set][0] = refMem[{tag[3:0], set, 1'b0}];
          refData[set][1] = refMem[{tag[3:0], set, 1'b1}];
          refTag[set] = tag;
          refSt[set]  = (r.op == opStore) ? lineModified : lineShared;
          expRd       = 2;
          if (r.op == opStore)
            expRdx = 2;
        end
        else if (r.op == opStore && refSt[set] == lineShared)
        begin
          refSt[set] = lineModified;
          expUp      = 1;
        end
        if (r.op == opStore)
          refData[set][w] = r.data;
      end
      opSnoopRd, opSnoopInv:
        if (present && refSt[set] == lineModified)
        begin
          expectWriteBack(set);
          refSt[set] = (r.op == opSnoopInv) ? lineInvalid : lineShared;
        end
        else if (present && r.op == opSnoopInv)
          refSt[set] = lineInvalid;   // clean copy just drops
      default:
        for (int s = 0; s < `DC_SETS; s++)
          if (refSt[s] == lineModified)
          begin
            expectWriteBack(`DC_IDX_W'(s));
            refSt[s] = lineShared;
          end
    endcase
  endtask

  task automatic nextDrive();
    @(posedge CLK);
    #1;
  endtask

  task automatic doAccess(stimRow r);
    int n;
    nextDrive();
    dmemRen   = (r.op == opLoad);
    dmemWen   = (r.op == opStore);
    dmemAddr  = r.addr;
    dmemStore = r.data;
    n = 0;
    do
    begin
      @(negedge CLK);   // dHit settles mid-cycle
      n++;
    end
    while (!dHit && n < waitLimit);
    if (!dHit)
    begin
      $display("Timed out at %0t ns waiting for dHit on address %h", $time, r.addr);
      hung = 1'b1;
    end
    else if (r.op == opLoad)
      checkWord(dmemLoad, r.expData, "load data");
    nextDrive();
    dmemRen = 1'b0;
    dmemWen = 1'b0;
  endtask

  task automatic runSnoopOrFlush(stimRow r);
    int n;
    nextDrive();
    if (r.op == opFlush)
      halt = 1'b1;   // stays up while the cache parks
    else
    begin
      ccSnoopAddr = r.addr;
      ccInv       = (r.op == opSnoopInv);
      ccWait      = 1'b1;
    end
    n = 0;
    do
    begin
      nextDrive();
      n++;
    end
    while (!((r.op == opFlush) ? flushed : ccDone) && n < waitLimit);
    ccWait = 1'b0;
    ccInv  = 1'b0;
    if (!((r.op == opFlush) ? flushed : ccDone))
    begin
      $display("Timed out at %0t ns waiting for the cache to finish %s", $time, r.op.name());
      hung = 1'b1;
    end
    else if (r.op == opFlush)
    begin
      repeat (4) nextDrive();
      checkCount(int'(flushed), 1, "flushed level");
    end
  endtask

  task automatic runRow(stimRow r, int num);
    rowErrs  = 0;
    expRd    = 0;
    expRdx   = 0;
    expUp    = 0;
    rdBeats  = 0;
    rdxBeats = 0;
    upBeats  = 0;
    expAddrQ.delete();
    expDataQ.delete();
    wbAddrQ.delete();
    wbDataQ.delete();
    predict(r);
    if (r.op == opLoad || r.op == opStore)
      doAccess(r);
    else
      runSnoopOrFlush(r);
    if (!hung)
    begin
      checkCount(rdBeats, expRd, "fetch beats");
      checkCount(rdxBeats, expRdx, "exclusive fetch beats");
      checkCount(upBeats, expUp, "upgrade grants");
      checkCount(wbAddrQ.size(), expAddrQ.size(), "write-back beats");
      if (wbAddrQ.size() == expAddrQ.size())
        foreach (expAddrQ[i])
        begin
          checkWord(wbAddrQ[i], expAddrQ[i], "write-back address");
          checkWord(wbDataQ[i], expDataQ[i], "write-back data");
        end
    end
    errCount += rowErrs;
    if (rowErrs != 0 || hung)
      badRows++;
    $display("row %0d %s %h %s", num, r.op.name(), r.addr,
             (rowErrs == 0 && !hung) ? "ok" : "FAILED");
  endtask

  initial
  begin
    rstN        = 1'b0;
    dmemRen     = 1'b0;
    dmemWen     = 1'b0;
    halt        = 1'b0;
    ccWait      = 1'b0;
    ccInv       = 1'b0;
    dmemAddr    = '0;
    dmemStore   = '0;
    ccSnoopAddr = '0;
    memWait     = 1'b1;
    memLoad     = '0;
    nextLoad    = '0;
    hung        = 1'b0;
    for (int i = 0; i < 256; i++)
    begin
      memArr[i] = 32'hd00d_0000 | memWord'(i << 2);   // word carries its byte address
      refMem[i] = memArr[i];
    end
    for (int s = 0; s < `DC_SETS; s++)
      refSt[s] = lineInvalid;
    addRow(opLoad, 32'h048, '0, 32'hd00d_0048);       // cold miss with 2 beats
    addRow(opLoad, 32'h04c, '0, 32'hd00d_004c);       // same block hits
    addRow(opStore, 32'h04c, 32'h1111_2222, '0);      // shared line needs an upgrade
    addRow(opLoad, 32'h04c, '0, 32'h1111_2222);
    addRow(opSnoopRd, 32'h048, '0, '0);               // dirty line writes back
    addRow(opLoad, 32'h048, '0, 32'hd00d_0048);
    addRow(opStore, 32'h048, 32'h3333_4444, '0);      // upgrade again
    addRow(opLoad, 32'h090, '0, 32'hd00d_0090);
    addRow(opSnoopInv, 32'h090, '0, '0);              // clean drop
    addRow(opLoad, 32'h094, '0, 32'hd00d_0094);
    addRow(opLoad, 32'h0c8, '0, 32'hd00d_00c8);       // evicts dirty set 1
    addRow(opLoad, 32'h04c, '0, 32'h1111_2222);
    addRow(opStore, 32'h1a0, 32'h5555_6666, '0);      // store miss
    addRow(opStore, 32'h3fc, 32'h7777_8888, '0);
    addRow(opSnoopInv, 32'h1a4, '0, '0);
    addRow(opLoad, 32'h1a4, '0, 32'hd00d_01a4);
    addRow(opStore, 32'h0d8, 32'h9999_aaaa, '0);
    addRow(opFlush, '0, '0, '0);
    repeat (2) @(posedge CLK);
    #1;
    rstN = 1'b1;
    foreach (rows[i])
    begin
      runRow(rows[i], i);
      rowsRun++;
      if (hung)
        break;
    end
    $display("%0d rows run, %0d failed, %0d mismatches", rowsRun, badRows, errCount);
    if (errCount == 0 && badRows == 0 && !hung)
      $display("RESULT: PASS");
    else
      $display("RESULT: FAIL");
    $finish;
  end

endmodule

// File: tests/dcache_assert.sv
// concurrent checks on bus direction, coherence start, flush level and hit timing
module dcacheAssert (
  input logic CLK,
  input logic rstN,
  input logic memRen,
  input logic memWen,
  input logic ccTrans,
  input logic ccWait,
  input logic dHit,
  input logic flushed
);
  timeunit 1ns;
  timeprecision 100ps;

  busOneDir: assert property (@(posedge CLK) disable iff (!rstN) !(memRen && memWen))
    else $error("memRen and memWen are high together");

  // own transaction only starts when no snoop was presented
  transNoSnoop: assert property (@(posedge CLK) disable iff (!rstN) $rose(ccTrans) |-> !$past(ccWait))
    else $error("ccTrans rose while ccWait was high");

  flushSticky: assert property (@(posedge CLK) disable iff (!rstN) flushed |=> flushed)
    else $error("flushed dropped before reset");

  hitNoBus: assert property (@(posedge CLK) disable iff (!rstN) !(dHit && (memRen || memWen)))
    else $error("dHit is high during a memory beat");

endmodule

bind dcacheTop dcacheAssert uAssert (.*);

// File: hw/dcacheTop.sv
// data cache top level joining the controller FSM and the storage arrays
`include "dcache_params.svh"

module dcacheTop (
  input  logic              CLK,
  input  logic              rstN,
  input  logic              dmemRen,
  input  logic              dmemWen,
  input  logic              halt,
  input  logic              memWait,
  input  logic              ccWait,
  input  logic              ccInv,
  input  dcachePkg::memWord dmemAddr,
  input  dcachePkg::memWord dmemStore,
  input  dcachePkg::memWord memLoad,
  input  dcachePkg::memWord ccSnoopAddr,
  output dcachePkg::memWord dmemLoad,
  output dcachePkg::memWord memAddr,
  output dcachePkg::memWord memStore,
  output logic              dHit,
  output logic              memRen,
  output logic              memWen,
  output logic              ccTrans,
  output logic              ccWrite,
  output logic              ccDone,
  output logic              flushed
);
  import dcachePkg::*;

  // controller to store
  memWord               lookupAddr;
  logic                 hitValid, tagMatch;
  lineState             lineSt, stNext;
  logic [`DC_TAG_W-1:0] victimTag;
  memWord               rdWord, wrWord;
  logic [`DC_IDX_W-1:0] scanIdx;
  logic                 useScan, wrEn, setTag, stEn;

  dcacheCtrl uCtrl (.*);
  dcacheStore uStore (.*);

  // selected word feeds both the load data and write-back data
  assign dmemLoad = rdWord;
  assign memStore = rdWord;

endmodule

// File: hw/dcacheCtrl.sv
// MSI controller FSM for hits, fills, write-backs, upgrades, snoops and the halt flush
`include "dcache_params.svh"

module dcacheCtrl (
  input  logic                  CLK,
  input  logic                  rstN,
  // datapath side
  input  logic                  dmemRen,
  input  logic                  dmemWen,
  input  dcachePkg::memWord     dmemAddr,
  input  dcachePkg::memWord     dmemStore,
  input  logic                  halt,
  output logic                  dHit,
  output logic                  flushed,
  // memory side
  output logic                  memRen,
  output logic                  memWen,
  output dcachePkg::memWord     memAddr,
  input  dcachePkg::memWord     memLoad,
  input  logic                  memWait,
  // coherence side
  output logic                  ccTrans,
  output logic                  ccWrite,
  output logic                  ccDone,
  input  logic                  ccWait,
  input  logic                  ccInv,
  input  dcachePkg::memWord     ccSnoopAddr,
  // store side
  output dcachePkg::memWord     lookupAddr,
  input  logic                  hitValid,
  input  logic                  tagMatch,
  input  dcachePkg::lineState   lineSt,
  input  logic [`DC_TAG_W-1:0]  victimTag,
  output logic [`DC_IDX_W-1:0]  scanIdx,
  output logic                  useScan,
  output logic                  wrEn,
  output dcachePkg::memWord     wrWord,
  output logic                  setTag,
  output logic                  stEn,
  output dcachePkg::lineState   stNext
);
  import dcachePkg::*;

  ctrlState             state, nextState;
  logic                 beat, nextBeat;       // word within the burst
  logic [`DC_IDX_W-1:0] scanCnt, nextScan;    // flush set counter
  logic                 nextDone;
  logic                 snoopReq;
  logic                 loadHit, storeHit;
  logic                 lastSet;
  logic                 beatDone;
  logic [`DC_IDX_W-1:0] reqIdx;

  assign reqIdx   = dmemAddr[`DC_IDX_LSB +: `DC_IDX_W];
  assign snoopReq = ccWait && !ccDone;   // ccWait still up in the ccDone cycle
  assign loadHit  = dmemRen && hitValid;
  assign storeHit = dmemWen && hitValid && (lineSt == lineModified);
  assign lastSet  = (scanCnt == `DC_IDX_W'(`DC_SETS - 1));
  assign beatDone = !memWait;            // memory took the beat

  // state decodes
  assign dHit    = (state == stIdle) && !ccWait && (loadHit || storeHit);
  assign memRen  = (state == stFetch);
  assign memWen  = (state == stWriteBack) || (state == stSnoopWb) || (state == stFlushWb);
  assign ccTrans = (state == stWriteBack) || (state == stFetch) || (state == stUpgrade);
  assign ccWrite = ccTrans && dmemWen;   // store wants the line exclusive
  assign flushed = (state == stHalted);
  assign useScan = (state == stFlushScan) || (state == stFlushWb);
  assign scanIdx = scanCnt;

  // store lookup address
  always_comb
  begin
    lookupAddr = {dmemAddr[`DC_WORD_W-1:`DC_IDX_LSB], beat, 2'b00};
    if (state == stIdle)
      lookupAddr = ccWait ? ccSnoopAddr : dmemAddr;   // snoop probe has priority
    else if (state == stSnoopWb)
      lookupAddr = {ccSnoopAddr[`DC_WORD_W-1:`DC_IDX_LSB], beat, 2'b00};
    else if (useScan)
      lookupAddr = {{(`DC_WORD_W - 3){1'b0}}, beat, 2'b00};   // index from scanIdx
  end

  // memory address, victim bursts rebuild from the resident tag
  always_comb
  begin
    case (state)
      stWriteBack: memAddr = {victimTag, reqIdx, beat, 2'b00};
      stFlushWb:   memAddr = {victimTag, scanCnt, beat, 2'b00};
      default:     memAddr = lookupAddr;
    endcase
  end

  always_comb
  begin
    nextState = state;
    nextBeat  = beat;
    nextScan  = scanCnt;
    nextDone  = 1'b0;
    wrEn      = 1'b0;
    wrWord    = dmemStore;
    setTag    = 1'b0;
    stEn      = 1'b0;
    stNext    = lineInvalid;
    case (state)
      stIdle:
      begin
        nextBeat = 1'b0;
        if (ccWait)
        begin
          if (snoopReq)
          begin
            if (hitValid && (lineSt == lineModified))
              nextState = stSnoopWb;
            else
            begin
              stEn     = ccInv && hitValid;   // drop a clean copy on invalidate
              nextDone = 1'b1;
            end
          end
        end
        else if (dmemRen || dmemWen)
        begin
          if (loadHit || storeHit)
            wrEn = dmemWen;                   // store hit lands now
          else if (dmemWen && tagMatch && (lineSt == lineShared))
            nextState = stUpgrade;
          else if (lineSt == lineModified)
            nextState = stWriteBack;          // dirty victim first
          else
            nextState = stFetch;
        end
        else if (halt)
          nextState = stFlushScan;
      end
      stWriteBack:
        if (beatDone)
        begin
          nextBeat = !beat;
          if (beat)
          begin
            stEn      = 1'b1;                 // victim now invalid
            nextState = stFetch;
          end
        end
      stFetch:
        if (beatDone)
        begin
          wrEn     = 1'b1;
          wrWord   = memLoad;
          nextBeat = !beat;
          if (beat)
          begin
            setTag    = 1'b1;
            stEn      = 1'b1;
            stNext    = dmemWen ? lineModified : lineShared;
            nextState = stIdle;               // hit follows next cycle
          end
        end
      stUpgrade:
        if (beatDone)
        begin
          stEn      = 1'b1;
          stNext    = lineModified;
          nextState = stIdle;
        end
      stSnoopWb:
        if (beatDone)
        begin
          nextBeat = !beat;
          if (beat)
          begin
            stEn      = 1'b1;
            stNext    = ccInv ? lineInvalid : lineShared;
            nextDone  = 1'b1;
            nextState = stIdle;
          end
        end
      stFlushScan:
        if (lineSt == lineModified)
          nextState = stFlushWb;
        else if (lastSet)
          nextState = stHalted;
        else
          nextScan = scanCnt + 1'b1;
      stFlushWb:
        if (beatDone)
        begin
          nextBeat = !beat;
          if (beat)
          begin
            stEn   = 1'b1;
            stNext = lineShared;              // memory now holds the data
            if (lastSet)
              nextState = stHalted;
            else
            begin
              nextScan  = scanCnt + 1'b1;
              nextState = stFlushScan;
            end
          end
        end
      stHalted:
        nextState = stHalted;                 // only reset leaves
      default:
        nextState = stIdle;
    endcase
  end

  always_ff @(posedge CLK or negedge rstN)
  begin
    if (!rstN)
    begin
      state   <= stIdle;
      beat    <= 1'b0;
      scanCnt <= '0;
      ccDone  <= 1'b0;
    end
    else
    begin
      state   <= nextState;
      beat    <= nextBeat;
      scanCnt <= nextScan;
      ccDone  <= nextDone;    // one-cycle pulse
    end
  end

endmodule

// File: hw/dcacheStore.sv
// tag, line-state and data arrays with one lookup port and registered write ports
`include "dcache_params.svh"

module dcacheStore (
  input  logic                  CLK,
  input  logic                  rstN,
  input  dcachePkg::memWord     lookupAddr,
  output logic                  hitValid,
  output logic                  tagMatch,
  output dcachePkg::lineState   lineSt,
  output logic [`DC_TAG_W-1:0]  victimTag,
  output dcachePkg::memWord     rdWord,
  input  logic [`DC_IDX_W-1:0]  scanIdx,
  input  logic                  useScan,
  input  logic                  wrEn,
  input  dcachePkg::memWord     wrWord,
  input  logic                  setTag,
  input  logic                  stEn,
  input  dcachePkg::lineState   stNext
);
  import dcachePkg::*;

  logic [`DC_TAG_W-1:0] tagArr [`DC_SETS];
  lineState             stArr [`DC_SETS];
  memWord               dataArr [`DC_SETS][2];

  logic [`DC_IDX_W-1:0] idx;
  logic                 wsel;
  logic [`DC_TAG_W-1:0] reqTag;

  // flush walks sets by counter, everything else by address
  assign idx    = useScan ? scanIdx : lookupAddr[`DC_IDX_LSB +: `DC_IDX_W];
  assign wsel   = lookupAddr[`DC_WSEL_BIT];
  assign reqTag = lookupAddr[`DC_WORD_W-1 -: `DC_TAG_W];

  // lookup, all combinational
  assign lineSt    = stArr[idx];
  assign victimTag = tagArr[idx];     // resident tag, used for write-back address
  assign tagMatch  = (tagArr[idx] == reqTag);
  assign hitValid  = tagMatch && (stArr[idx] != lineInvalid);
  assign rdWord    = dataArr[idx][wsel];

  // line states, reset leaves all lines invalid
  always_ff @(posedge CLK or negedge rstN)
  begin
    if (!rstN)
    begin
      for (int i = 0; i < `DC_SETS; i++)
        stArr[i] <= lineInvalid;
    end
    else if (stEn)
    begin
      stArr[idx] <= stNext;
    end
  end

  // tags and data
  always_ff @(posedge CLK)
  begin
    if (setTag)
      tagArr[idx] <= reqTag;  // installed on the last fill beat
    if (wrEn)
      dataArr[idx][wsel] <= wrWord;
  end

endmodule

// File: hw/dcachePkg.sv
// word, MSI line-state and controller FSM types shared by the data cache
`include "dcache_params.svh"

package dcachePkg;

  // data or address word
  typedef logic [`DC_WORD_W-1:0] memWord;

  // MSI state of one line
  typedef enum logic [1:0] {
    lineInvalid,
    lineShared,
    lineModified
  } lineState;

  typedef enum logic [2:0] {
    stIdle,      // hits, snoop accept, request decode
    stWriteBack, // victim burst before a fill
    stFetch,     // two-beat fill
    stUpgrade,   // shared to modified, no data
    stSnoopWb,   // dirty data out for a snoop
    stFlushScan, // walk the sets on halt
    stFlushWb,   // write one dirty line during flush
    stHalted     // flush done, parked
  } ctrlState;

endpackage

// File: hw/dcache_params.svh
// geometry and address field macros for the direct-mapped data cache
`ifndef DCACHE_PARAMS_SVH
`define DCACHE_PARAMS_SVH

// 8 sets of 2-word blocks
`define DC_SETS 8
`define DC_IDX_W 3

// tag is everything above the index
`define DC_TAG_W 26

// data and address word
`define DC_WORD_W 32

// byte address layout
// bits 1:0 byte offset, ignored
`define DC_WSEL_BIT 2
// index starts right above the word select
`define DC_IDX_LSB 3
// tag field is the top DC_TAG_W bits of the word

`endif
